//--- rtl/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module fetch_buffer import fetch_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  redirect_t  redirect,
  output mem_req_t   mem_req,
  input  mem_resp_t  mem_resp,
  output issue_t     issue,
  input  logic [1:0] credit_return
);

  bank_wr_t                        bank_wr;
  bank_rd_t                        bank_rd;
  bank_data_t                      bank_data;
  align_res_t                      align_res;
  logic [$clog2(`BUFFER_DEPTH)+2:0] parcel_count;
  logic [1:0]                      first_offset;

  fetch_ctrl ctrl0 (
    .clock         (clock),
    .reset         (reset),
    .redirect      (redirect),
    .mem_req       (mem_req),
    .mem_resp      (mem_resp),
    .bank_wr       (bank_wr),
    .bank_rd       (bank_rd),
    .parcel_count  (parcel_count),
    .first_offset  (first_offset),
    .align_res     (align_res),
    .credit_return (credit_return),
    .issue         (issue)
  );

  parcel_banks banks0 (
    .clock     (clock),
    .bank_wr   (bank_wr),
    .bank_rd   (bank_rd),
    .bank_data (bank_data)
  );

  instr_align align0 (
    .bank_data    (bank_data),
    .parcel_count (parcel_count),
    .first_offset (first_offset),
    .align_res    (align_res)
  );

endmodule

`default_nettype wire

//--- rtl/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// entries per bank, four banks in total
`define BUFFER_DEPTH 8

// decode slots granted after reset
`define ISSUE_CREDITS 4

// block reads allowed in flight
`define MAX_OUTSTANDING 4

`endif

//--- rtl/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module fetch_ctrl import fetch_pkg::*; (
  input  logic                            clock,
  input  logic                            reset,
  input  redirect_t                       redirect,
  output mem_req_t                        mem_req,
  input  mem_resp_t                       mem_resp,
  output bank_wr_t                        bank_wr,
  output bank_rd_t                        bank_rd,
  output logic [$clog2(`BUFFER_DEPTH)+2:0] parcel_count,
  output logic [1:0]                      first_offset,
  input  align_res_t                      align_res,
  input  logic [1:0]                      credit_return,
  output issue_t                          issue
);

  localparam int ptr_w = $clog2(`BUFFER_DEPTH) + 2;
  localparam int cnt_w = ptr_w + 1;
  localparam int fill_w = cnt_w + 1;
  localparam int live_w = $clog2(`MAX_OUTSTANDING + 1);
  localparam int drop_w = $clog2(2 * `MAX_OUTSTANDING + 1);
  localparam int credit_w = $clog2(`ISSUE_CREDITS + 1);
  localparam logic [fill_w-1:0] capacity = fill_w'(4 * `BUFFER_DEPTH);

  fetch_state_t         state;
  logic [ptr_w-1:0]     wr_ptr;
  logic [ptr_w-1:0]     rd_ptr;
  logic [cnt_w-1:0]     count;
  logic [1:0]           skip;      // parcels ahead of the target in the first block
  logic [live_w-1:0]    live;      // requests whose data will be kept
  logic [drop_w-1:0]    drop;      // wrong-path responses still to come
  logic [credit_w-1:0]  credits;
  logic [31:0]          req_pc;
  logic [31:0]          resp_pc;

  logic [fill_w-1:0]    fill;
  logic                 room_one;
  logic                 room_two;
  logic                 req_fire;
  logic                 resp_live;
  logic                 resp_drop;
  logic                 kept;
  logic [live_w-1:0]    live_after;
  logic [drop_w-1:0]    drop_after;
  logic [2:0]           wr_add;
  logic [2:0]           used;
  logic [1:0]           n_issued;
  bank_addr_t           rd_row;

  // buffered parcels plus space reserved for blocks in flight
  assign fill = fill_w'(count) + fill_w'({live, 2'b00});
  assign room_one = (fill + fill_w'(4)) <= capacity;
  assign room_two = (fill + fill_w'(8)) <= capacity;

  always_comb begin
    case (state)
      state_fetch: req_fire = room_one;
      state_drain: req_fire = room_two;  // resume with some slack
      default:     req_fire = 1'b0;
    endcase
    if (live == live_w'(`MAX_OUTSTANDING) ||
        (drop + drop_w'(live)) >= drop_w'(2 * `MAX_OUTSTANDING)) begin
      req_fire = 1'b0;
    end
  end

  assign mem_req.valid = req_fire;
  assign mem_req.addr = req_pc;

  // responses come back in order, so dropped ones are always the oldest
  assign resp_drop = mem_resp.valid && (drop != '0);
  assign resp_live = mem_resp.valid && (drop == '0);
  assign kept = resp_live && !redirect.valid;
  assign live_after = live + live_w'(req_fire) - live_w'(resp_live);
  assign drop_after = drop - drop_w'(resp_drop);
  assign wr_add = kept ? (3'd4 - {1'b0, skip}) : 3'd0;

  always_comb begin
    bank_wr.en = kept;
    bank_wr.idx = wr_ptr[ptr_w-1:2];
    for (int i = 0; i < 4; i++) begin
      bank_wr.parcel[i].addr = {resp_pc[31:3], 2'(i), 1'b0};
      bank_wr.parcel[i].data = mem_resp.data[16*i +: 16];
    end
  end

  assign rd_row = rd_ptr[ptr_w-1:2];
  assign first_offset = rd_ptr[1:0];
  assign parcel_count = count;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      // lanes behind the offset hold the following row
      bank_rd.idx[i] = (2'(i) < first_offset) ? rd_row + 1'b1 : rd_row;
    end
  end

  always_comb begin
    issue.slot0 = align_res.slot0;
    issue.slot1 = align_res.slot1;
    issue.slot0.valid = align_res.slot0.valid && (credits != '0) && !redirect.valid;
    issue.slot1.valid = align_res.slot1.valid && (credits >= credit_w'(2)) &&
                        issue.slot0.valid;
    if (issue.slot1.valid) begin
      used = align_res.used;
    end else if (issue.slot0.valid) begin
      used = issue.slot0.compressed ? 3'd1 : 3'd2;
    end else begin
      used = 3'd0;
    end
    n_issued = {1'b0, issue.slot0.valid} + {1'b0, issue.slot1.valid};
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= state_idle;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      skip <= '0;
      live <= '0;
      drop <= '0;
      credits <= credit_w'(`ISSUE_CREDITS);
    end else begin
      credits <= credits + credit_w'(credit_return) - credit_w'(n_issued);
      if (redirect.valid) begin
        state <= state_fetch;
        wr_ptr <= '0;
        rd_ptr <= ptr_w'(redirect.pc[2:1]);
        count <= '0;
        skip <= redirect.pc[2:1];
        live <= '0;
        drop <= drop_after + drop_w'(live_after);  // everything in flight is stale
      end else begin
        live <= live_after;
        drop <= drop_after;
        rd_ptr <= rd_ptr + ptr_w'(used);
        count <= count + cnt_w'(wr_add) - cnt_w'(used);
        if (kept) begin
          wr_ptr <= wr_ptr + ptr_w'(4);
          skip <= '0;
        end
        case (state)
          state_fetch: if (!room_one) state <= state_drain;
          state_drain: if (room_two) state <= state_fetch;
          default:     state <= state_idle;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (redirect.valid) begin
      req_pc <= {redirect.pc[31:3], 3'b000};
      resp_pc <= {redirect.pc[31:3], 3'b000};
    end else begin
      if (req_fire) begin
        req_pc <= req_pc + 32'd8;
      end
      if (kept) begin
        resp_pc <= resp_pc + 32'd8;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/fetch_pkg.sv
`default_nettype none

`include "fetch_config.svh"

package fetch_pkg;

  typedef logic [$clog2(`BUFFER_DEPTH)-1:0] bank_addr_t;

  typedef struct packed {
    logic [31:0] addr;  // byte address of this parcel
    logic [15:0] data;
  } parcel_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;  // 8-byte aligned
  } mem_req_t;

  typedef struct packed {
    logic        valid;
    logic [63:0] data;
  } mem_resp_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
  } redirect_t;

  typedef struct packed {
    logic            en;
    bank_addr_t      idx;
    parcel_t [3:0]   parcel;
  } bank_wr_t;

  typedef struct packed {
    bank_addr_t [3:0] idx;  // one per bank
  } bank_rd_t;

  typedef struct packed {
    parcel_t [3:0] parcel;
  } bank_data_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        compressed;
  } slot_t;

  typedef struct packed {
    slot_t slot0;  // older
    slot_t slot1;
  } issue_t;

  typedef struct packed {
    slot_t       slot0;
    slot_t       slot1;
    logic [2:0]  used;  // parcels consumed
  } align_res_t;

  typedef enum logic [1:0] {
    state_idle,
    state_fetch,
    state_drain
  } fetch_state_t;

endpackage

`default_nettype wire

//--- rtl/instr_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module instr_align import fetch_pkg::*; (
  input  bank_data_t                      bank_data,
  input  logic [$clog2(`BUFFER_DEPTH)+2:0] parcel_count,
  input  logic [1:0]                      first_offset,
  output align_res_t                      align_res
);

  parcel_t [3:0] rot;   // oldest parcel in rot[0]
  logic [2:0]    avail;
  logic [2:0]    pos;
  logic [2:0]    need;

  // builds one slot starting at lo, hi only matters for a 32-bit instruction
  function automatic slot_t make_slot(input parcel_t lo, input parcel_t hi);
    slot_t s;
    s.valid = 1'b1;
    s.pc = lo.addr;
    s.compressed = (lo.data[1:0] != 2'b11);
    if (s.compressed) begin
      s.instr = {16'h0000, lo.data};
    end else begin
      s.instr = {hi.data, lo.data};
    end
    return s;
  endfunction

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      rot[i] = bank_data.parcel[2'(first_offset + 2'(i))];
    end

    avail = (parcel_count >= 4) ? 3'd4 : 3'(parcel_count);

    align_res = '0;
    pos = 3'd0;

    need = (rot[0].data[1:0] == 2'b11) ? 3'd2 : 3'd1;
    if (avail >= need) begin
      align_res.slot0 = make_slot(rot[0], rot[1]);
      pos = need;
    end

    // second slot only follows a complete first one
    if (pos != 3'd0) begin
      need = (rot[pos[1:0]].data[1:0] == 2'b11) ? 3'd2 : 3'd1;
      if (avail >= pos + need) begin
        align_res.slot1 = make_slot(rot[pos[1:0]], rot[pos[1:0] + 2'd1]);
        pos = pos + need;
      end
    end

    align_res.used = pos;
  end

endmodule

`default_nettype wire

//--- rtl/parcel_banks.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module parcel_banks import fetch_pkg::*; (
  input  logic       clock,
  input  bank_wr_t   bank_wr,
  input  bank_rd_t   bank_rd,
  output bank_data_t bank_data
);

  genvar b;

  generate
    for (b = 0; b < 4; b++) begin : gen_bank
      parcel_t entries [0:`BUFFER_DEPTH-1];
      parcel_t rd_entry;

      // all banks share the write row
      always_ff @(posedge clock) begin
        if (bank_wr.en) begin
          entries[bank_wr.idx] <= bank_wr.parcel[b];
        end
      end

      assign rd_entry = entries[bank_rd.idx[b]];

      always_comb begin
        if (bank_wr.en && (bank_rd.idx[b] == bank_wr.idx)) begin
          bank_data.parcel[b] = bank_wr.parcel[b];  // bypass
        end else begin
          bank_data.parcel[b] = rd_entry;
        end
      end
    end
  endgenerate

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_ctrl.sv
rtl/parcel_banks.sv
rtl/instr_align.sv
rtl/fetch_buffer.sv
verification/fetch_mem_model.sv
verification/tb_fetch_buffer.sv

//--- verification/fetch_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_mem_model import fetch_pkg::*; (
  input  logic      clock,
  input  mem_req_t  mem_req,
  output mem_resp_t mem_resp
);

  integer      seed;
  int          cycle;
  int          last_due;
  logic [31:0] pend_addr [$];
  int          pend_due [$];

  // program parcel at a byte address, low bits pick 16 or 32 bit encodings
  function automatic logic [15:0] parcel_at(input logic [31:0] addr);
    logic [31:0] h;
    h = addr * 32'h9e37_79b1;
    h = h ^ (h >> 13);
    return {h[31:18], h[7] ? 2'b11 : {1'b0, h[9]}};
  endfunction

  function automatic logic [63:0] block_at(input logic [31:0] addr);
    return {parcel_at(addr + 32'd6), parcel_at(addr + 32'd4),
            parcel_at(addr + 32'd2), parcel_at(addr)};
  endfunction

  initial begin
    seed = 32'hf988_99cd;
    cycle = 0;
    last_due = 0;
    mem_resp = '0;
  end

  always @(negedge clock) begin
    int due;
    if (mem_req.valid) begin
      due = cycle + 1 + ($random(seed) & 3);  // 1 to 4 cycles
      if (due <= last_due) begin
        due = last_due + 1;  // keep responses in order
      end
      pend_addr.push_back(mem_req.addr);
      pend_due.push_back(due);
      last_due = due;
    end
  end

  always @(posedge clock) begin
    cycle = cycle + 1;
    #1;
    if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
      mem_resp = {1'b1, block_at(pend_addr.pop_front())};
      void'(pend_due.pop_front());
    end else begin
      mem_resp = '0;
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module tb_fetch_buffer import fetch_pkg::*; ();

  localparam int test_lengths = 10 + 60 + 40 + 60 + 40;  // cycles or instructions per test
  localparam int cycle_limit = test_lengths * 20;

  logic       clock = 1'b0;
  logic       reset;
  redirect_t  redirect;
  mem_req_t   mem_req;
  mem_resp_t  mem_resp;
  issue_t     issue;
  logic [1:0] credit_return;

  logic        hold;          // decode keeps its slots
  int          held;          // mirror of the DUT credit count
  int          pending;       // slots decode has not freed yet
  int          cycles;
  int          issued_since;
  int          req_since;
  int          span_since;
  logic [31:0] exp_pc;
  logic [31:0] exp_req;

  fetch_buffer dut0 (
    .clock         (clock),
    .reset         (reset),
    .redirect      (redirect),
    .mem_req       (mem_req),
    .mem_resp      (mem_resp),
    .issue         (issue),
    .credit_return (credit_return)
  );

  fetch_mem_model mem0 (
    .clock    (clock),
    .mem_req  (mem_req),
    .mem_resp (mem_resp)
  );

  always #2 clock = ~clock;

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_slot(input string name, input slot_t exp, input slot_t act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_req(input string name, input mem_req_t exp, input mem_req_t act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  // reference walk of the program from exp_pc
  function automatic slot_t expected_slot(input logic [31:0] pc);
    slot_t       s;
    logic [15:0] lo;
    lo = mem0.parcel_at(pc);
    s.valid = 1'b1;
    s.pc = pc;
    s.compressed = (lo[1:0] != 2'b11);
    s.instr = s.compressed ? {16'h0000, lo} : {mem0.parcel_at(pc + 32'd2), lo};
    return s;
  endfunction

  task automatic score_issue(input string name, input slot_t act);
    slot_t exp;
    exp = expected_slot(exp_pc);
    compare_slot(name, exp, act);
    if (!exp.compressed && exp_pc[2:1] == 2'd3) begin
      span_since++;  // upper half sits in the next block
    end
    exp_pc = exp_pc + (exp.compressed ? 32'd2 : 32'd4);
    issued_since++;
  endtask

  always @(negedge clock) begin
    int n;
    if (reset) begin
      n = int'(issue.slot0.valid) + int'(issue.slot1.valid);
      if (issue.slot1.valid && !issue.slot0.valid) begin
        $display("slot1 issued without slot0 at %0t", $time);
        abort_run();
      end
      if (n > held) begin
        $display("more instructions issued than credits held at %0t", $time);
        abort_run();
      end
      if (issue.slot0.valid) score_issue("issue.slot0", issue.slot0);
      if (issue.slot1.valid) score_issue("issue.slot1", issue.slot1);
      held = held - n;
      pending = pending + n;
      if (mem_req.valid) begin
        compare_req("mem_req", {1'b1, exp_req}, mem_req);
        exp_req = exp_req + 32'd8;
        req_since++;
      end
      if (redirect.valid) begin
        exp_pc = redirect.pc;
        exp_req = {redirect.pc[31:3], 3'b000};
        issued_since = 0;
        req_since = 0;
        span_since = 0;
      end
    end
  end

  // decode side frees up to two slots per cycle
  always @(posedge clock) begin
    int r;
    held = held + int'(credit_return);
    #1;
    r = (hold || !reset) ? 0 : ((pending > 2) ? 2 : pending);
    credit_return = 2'(r);
    pending = pending - r;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_limit);
      abort_run();
    end
  end

  task automatic do_redirect(input logic [31:0] pc);
    @(posedge clock);
    #1;
    redirect = {1'b1, pc};
    @(posedge clock);
    #1;
    redirect = '0;
  endtask

  task automatic wait_issued(input int n);
    while (issued_since < n) @(posedge clock);
  endtask

  task automatic settle_memory();
    int quiet;
    quiet = 0;
    while (quiet < 12) begin
      @(negedge clock);
      quiet = (mem_req.valid || mem_resp.valid) ? 0 : quiet + 1;
    end
  endtask

  task automatic verify_reset_state();
    repeat (10) begin
      @(negedge clock);
      if (mem_req.valid !== 1'b0 || issue.slot0.valid !== 1'b0 ||
          issue.slot1.valid !== 1'b0) begin
        $display("request or issue seen before any redirect at %0t", $time);
        abort_run();
      end
    end
  endtask

  task automatic aligned_stream();
    do_redirect(32'h0000_1000);
    wait_issued(60);
    if (span_since == 0) begin
      $display("no instruction crossed a block boundary in the aligned stream");
      abort_run();
    end
  endtask

  task automatic misaligned_target();
    do_redirect(32'h0000_3006);  // only the last parcel of the first block
    wait_issued(40);
  endtask

  task automatic credit_stall();
    int stored;
    hold = 1'b1;
    do_redirect(32'h0000_5000);
    settle_memory();
    stored = req_since * 4 - int'((exp_pc - 32'h0000_5000) >> 1);
    if (issued_since > `ISSUE_CREDITS || held != 0) begin
      $display("issue did not stop at the credit limit, %0d issued", issued_since);
      abort_run();
    end
    if (stored <= 28 || stored > 4 * `BUFFER_DEPTH) begin
      $display("requests did not pause at a full buffer, %0d parcels held", stored);
      abort_run();
    end
    hold = 1'b0;
    wait_issued(60);
  endtask

  task automatic flush_in_flight();
    do_redirect(32'h0000_7002);
    wait_issued(3);
    do @(negedge clock); while (!mem_req.valid);
    do_redirect(32'h0000_9004);  // lands while that block is in flight
    wait_issued(40);
  endtask

  initial begin
    reset = 1'b0;
    redirect = '0;
    credit_return = '0;
    hold = 1'b0;
    held = `ISSUE_CREDITS;
    pending = 0;
    cycles = 0;
    issued_since = 0;
    req_since = 0;
    span_since = 0;
    exp_pc = '0;
    exp_req = '0;
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b1;
    verify_reset_state();
    aligned_stream();
    misaligned_target();
    credit_stall();
    flush_in_flight();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire
